// File: logic/cpu_pkg.sv
package cpu_pkg;

	localparam int data_w = 8;

	// the start PC is read from this address after reset.
	localparam logic [data_w-1:0] vector_addr = 8'h00;

	// SP pre-decrements on a push, so the first push lands at 0xFF.
	localparam logic [data_w-1:0] sp_reset = 8'h00;

	typedef enum logic [3:0] {
		ADD   = 4'h0,
		SUB   = 4'h1,
		AND   = 4'h2,
		XOR   = 4'h3,
		LDI   = 4'h4,
		LD    = 4'h5,
		ST    = 4'h6,
		JZ    = 4'h7,
		CALL  = 4'h8,
		PUSH  = 4'h9,
		POP   = 4'hA,
		RET   = 4'hB,
		NOP_C = 4'hC,
		NOP_D = 4'hD,
		NOP_E = 4'hE,
		HALT  = 4'hF
	} opcode_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [1:0] rd;
		logic [1:0] rs;
	} instr_reg_t;

	typedef struct packed {
		opcode_e    opcode;
		logic [3:0] imm4;
	} instr_imm_t;

	// one instruction byte, seen either with register fields or with the jump offset.
	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_t;

	typedef enum logic [2:0] {
		VECTOR,
		FETCH,
		DECODE,
		EXEC1,
		EXEC2,
		EXEC3,
		HALTED
	} state_e;

	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR} alu_op_e;

	typedef enum logic [1:0] {ADDR_PC, ADDR_RS, ADDR_SP, ADDR_VEC} addr_sel_e;

	typedef enum logic {WDATA_RD, WDATA_PC} wdata_sel_e;

	typedef enum logic {REG_ALU, REG_BUS} reg_src_e;

	typedef enum logic [1:0] {PC_INC, PC_BUS, PC_TMP, PC_REL} pc_src_e;

endpackage

// File: logic/cpu_ctrl_if.sv
interface cpu_ctrl_if;

	cpu_pkg::alu_op_e    alu_op;
	logic                alu_we;
	logic                reg_we;
	cpu_pkg::reg_src_e   reg_src;
	logic                ir_we;
	logic                pc_we;
	cpu_pkg::pc_src_e    pc_src;
	logic                tmp_we;
	logic                sp_inc;
	logic                sp_dec;
	cpu_pkg::addr_sel_e  addr_sel;
	cpu_pkg::wdata_sel_e wdata_sel;

	// status returned by the datapath.
	cpu_pkg::instr_t     instr;
	logic                z;

	modport ctrl (
		output alu_op, alu_we, reg_we, reg_src, ir_we, pc_we, pc_src,
		output tmp_we, sp_inc, sp_dec, addr_sel, wdata_sel,
		input  instr, z
	);

	modport dp (
		input  alu_op, alu_we, reg_we, reg_src, ir_we, pc_we, pc_src,
		input  tmp_we, sp_inc, sp_dec, addr_sel, wdata_sel,
		output instr, z
	);

endinterface

// File: logic/cpu_bus_if.sv
interface cpu_bus_if;

	logic                        req;
	logic                        we;
	logic [cpu_pkg::data_w-1:0]  adr;
	logic [cpu_pkg::data_w-1:0]  wdata;
	logic [cpu_pkg::data_w-1:0]  rdata;
	logic                        done;

	// req holds with adr, wdata and we stable until the cycle where done is high.
	modport ctrl (
		output req, we,
		input  done
	);

	modport dp (
		output adr, wdata,
		input  rdata
	);

	modport master (
		input  req, we, adr, wdata,
		output rdata, done
	);

endinterface

// File: logic/cpu_controller.sv
module cpu_controller (
	input  logic           clk,
	input  logic           nRst,
	cpu_ctrl_if.ctrl       ctrl,
	cpu_bus_if.ctrl        bus,
	output logic           halted
);

	cpu_pkg::state_e state;
	cpu_pkg::state_e state_next;

	// strobes default low and the bus states only raise them once done arrives.
	always_comb begin
		ctrl.alu_op    = cpu_pkg::ALU_ADD;
		ctrl.alu_we    = 1'b0;
		ctrl.reg_we    = 1'b0;
		ctrl.reg_src   = cpu_pkg::REG_ALU;
		ctrl.ir_we     = 1'b0;
		ctrl.pc_we     = 1'b0;
		ctrl.pc_src    = cpu_pkg::PC_INC;
		ctrl.tmp_we    = 1'b0;
		ctrl.sp_inc    = 1'b0;
		ctrl.sp_dec    = 1'b0;
		ctrl.addr_sel  = cpu_pkg::ADDR_PC;
		ctrl.wdata_sel = cpu_pkg::WDATA_RD;
		bus.req        = 1'b0;
		bus.we         = 1'b0;
		state_next     = state;
		case (state)
			cpu_pkg::VECTOR: begin
				bus.req       = 1'b1;
				ctrl.addr_sel = cpu_pkg::ADDR_VEC;
				ctrl.pc_src   = cpu_pkg::PC_BUS;
				if (bus.done) begin
					ctrl.pc_we = 1'b1;
					state_next = cpu_pkg::FETCH;
				end
			end
			cpu_pkg::FETCH: begin
				bus.req = 1'b1;
				if (bus.done) begin
					ctrl.ir_we = 1'b1;
					ctrl.pc_we = 1'b1;
					state_next = cpu_pkg::DECODE;
				end
			end
			cpu_pkg::DECODE: begin
				case (ctrl.instr.r.opcode)
					cpu_pkg::NOP_C, cpu_pkg::NOP_D, cpu_pkg::NOP_E: state_next = cpu_pkg::FETCH;
					cpu_pkg::HALT: state_next = cpu_pkg::HALTED;
					default: state_next = cpu_pkg::EXEC1;
				endcase
			end
			cpu_pkg::EXEC1: begin
				state_next = cpu_pkg::FETCH;
				case (ctrl.instr.r.opcode)
					cpu_pkg::ADD: begin
						ctrl.alu_op = cpu_pkg::ALU_ADD;
						ctrl.alu_we = 1'b1;
					end
					cpu_pkg::SUB: begin
						ctrl.alu_op = cpu_pkg::ALU_SUB;
						ctrl.alu_we = 1'b1;
					end
					cpu_pkg::AND: begin
						ctrl.alu_op = cpu_pkg::ALU_AND;
						ctrl.alu_we = 1'b1;
					end
					cpu_pkg::XOR: begin
						ctrl.alu_op = cpu_pkg::ALU_XOR;
						ctrl.alu_we = 1'b1;
					end
					cpu_pkg::LDI, cpu_pkg::LD: begin
						bus.req      = 1'b1;
						ctrl.reg_src = cpu_pkg::REG_BUS;
						if (ctrl.instr.r.opcode == cpu_pkg::LD)
							ctrl.addr_sel = cpu_pkg::ADDR_RS;
						if (!bus.done)
							state_next = state;
						else begin
							ctrl.reg_we = 1'b1;
							ctrl.pc_we  = (ctrl.instr.r.opcode == cpu_pkg::LDI);
						end
					end
					cpu_pkg::ST: begin
						bus.req       = 1'b1;
						bus.we        = 1'b1;
						ctrl.addr_sel = cpu_pkg::ADDR_RS;
						if (!bus.done)
							state_next = state;
					end
					cpu_pkg::JZ: begin
						ctrl.pc_src = cpu_pkg::PC_REL;
						ctrl.pc_we  = ctrl.z;
					end
					cpu_pkg::CALL: begin
						bus.req = 1'b1;
						if (!bus.done)
							state_next = state;
						else begin
							ctrl.tmp_we = 1'b1;
							ctrl.pc_we  = 1'b1;
							state_next  = cpu_pkg::EXEC2;
						end
					end
					cpu_pkg::PUSH: begin
						ctrl.sp_dec = 1'b1;
						state_next  = cpu_pkg::EXEC2;
					end
					cpu_pkg::POP, cpu_pkg::RET: begin
						bus.req       = 1'b1;
						ctrl.addr_sel = cpu_pkg::ADDR_SP;
						ctrl.reg_src  = cpu_pkg::REG_BUS;
						ctrl.pc_src   = cpu_pkg::PC_BUS;
						if (!bus.done)
							state_next = state;
						else begin
							ctrl.reg_we = (ctrl.instr.r.opcode == cpu_pkg::POP);
							ctrl.pc_we  = (ctrl.instr.r.opcode == cpu_pkg::RET);
							state_next  = cpu_pkg::EXEC2;
						end
					end
					default: ;
				endcase
			end
			cpu_pkg::EXEC2: begin
				state_next = cpu_pkg::FETCH;
				case (ctrl.instr.r.opcode)
					cpu_pkg::CALL: begin
						ctrl.sp_dec = 1'b1;
						state_next  = cpu_pkg::EXEC3;
					end
					cpu_pkg::PUSH: begin
						bus.req       = 1'b1;
						bus.we        = 1'b1;
						ctrl.addr_sel = cpu_pkg::ADDR_SP;
						if (!bus.done)
							state_next = state;
					end
					cpu_pkg::POP, cpu_pkg::RET: ctrl.sp_inc = 1'b1;
					default: ;
				endcase
			end
			cpu_pkg::EXEC3: begin
				// only CALL gets here; the return address goes out while PC loads the target.
				bus.req        = 1'b1;
				bus.we         = 1'b1;
				ctrl.addr_sel  = cpu_pkg::ADDR_SP;
				ctrl.wdata_sel = cpu_pkg::WDATA_PC;
				ctrl.pc_src    = cpu_pkg::PC_TMP;
				if (bus.done) begin
					ctrl.pc_we = 1'b1;
					state_next = cpu_pkg::FETCH;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst)
			state <= cpu_pkg::VECTOR;
		else
			state <= state_next;
	end

	assign halted = (state == cpu_pkg::HALTED);

endmodule

// File: logic/cpu_datapath.sv
module cpu_datapath (
	input  logic           clk,
	input  logic           nRst,
	cpu_ctrl_if.dp         ctrl,
	cpu_bus_if.dp          bus
);

	logic [cpu_pkg::data_w-1:0] regs [4];
	logic [cpu_pkg::data_w-1:0] pc;
	logic [cpu_pkg::data_w-1:0] sp;
	logic [cpu_pkg::data_w-1:0] tmp;
	logic [cpu_pkg::data_w-1:0] rd_val;
	logic [cpu_pkg::data_w-1:0] rs_val;
	logic [cpu_pkg::data_w-1:0] alu_y;
	logic [cpu_pkg::data_w-1:0] reg_wdata;
	logic [cpu_pkg::data_w-1:0] rel_off;
	logic [cpu_pkg::data_w-1:0] pc_next;
	cpu_pkg::instr_t            ir;
	logic                       z;

	assign rd_val = regs[ir.r.rd];
	assign rs_val = regs[ir.r.rs];

	always_comb begin
		case (ctrl.alu_op)
			cpu_pkg::ALU_ADD: alu_y = rd_val + rs_val;
			cpu_pkg::ALU_SUB: alu_y = rd_val - rs_val;
			cpu_pkg::ALU_AND: alu_y = rd_val & rs_val;
			default:          alu_y = rd_val ^ rs_val;
		endcase
	end

	assign reg_wdata = (!ctrl.alu_we && ctrl.reg_src == cpu_pkg::REG_BUS) ? bus.rdata : alu_y;

	// the jump offset counts from the byte after JZ, since PC has already moved past it.
	assign rel_off = {{(cpu_pkg::data_w-4){ir.i.imm4[3]}}, ir.i.imm4};

	always_comb begin
		case (ctrl.pc_src)
			cpu_pkg::PC_INC: pc_next = pc + 1'b1;
			cpu_pkg::PC_BUS: pc_next = bus.rdata;
			cpu_pkg::PC_TMP: pc_next = tmp;
			default:         pc_next = pc + rel_off;
		endcase
	end

	always_comb begin
		case (ctrl.addr_sel)
			cpu_pkg::ADDR_PC: bus.adr = pc;
			cpu_pkg::ADDR_RS: bus.adr = rs_val;
			cpu_pkg::ADDR_SP: bus.adr = sp;
			default:          bus.adr = cpu_pkg::vector_addr;
		endcase
	end

	assign bus.wdata = (ctrl.wdata_sel == cpu_pkg::WDATA_PC) ? pc : rd_val;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc <= '0;
			sp <= cpu_pkg::sp_reset;
			z  <= 1'b0;
		end else begin
			if (ctrl.pc_we)
				pc <= pc_next;
			if (ctrl.sp_dec)
				sp <= sp - 1'b1;
			else if (ctrl.sp_inc)
				sp <= sp + 1'b1;
			// loads and pops leave the flag alone.
			if (ctrl.alu_we)
				z <= (alu_y == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.alu_we || ctrl.reg_we)
			regs[ir.r.rd] <= reg_wdata;
		if (ctrl.ir_we)
			ir <= bus.rdata;
		if (ctrl.tmp_we)
			tmp <= bus.rdata;
	end

	assign ctrl.instr = ir;
	assign ctrl.z     = z;

endmodule

// File: logic/cpu_bus_master.sv
module cpu_bus_master (
	input  logic                        clk,
	input  logic                        nRst,
	cpu_bus_if.master                   bus,
	output logic                        wb_cyc,
	output logic                        wb_stb,
	output logic                        wb_we,
	output logic [cpu_pkg::data_w-1:0]  wb_adr,
	output logic [cpu_pkg::data_w-1:0]  wb_dat_w,
	input  logic [cpu_pkg::data_w-1:0]  wb_dat_r,
	input  logic                        wb_ack
);

	logic active;

	// a cycle opens the clock after req and closes the clock after ack.
	// the bus then idles for a cycle before the next request can open.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			active <= 1'b0;
			wb_we  <= 1'b0;
		end else if (!active) begin
			if (bus.req) begin
				active <= 1'b1;
				wb_we  <= bus.we;
			end
		end else if (wb_ack) begin
			active <= 1'b0;
			wb_we  <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!active && bus.req) begin
			wb_adr   <= bus.adr;
			wb_dat_w <= bus.wdata;
		end
	end

	assign wb_cyc = active;
	assign wb_stb = active;

	assign bus.done  = active && wb_ack;
	assign bus.rdata = wb_dat_r;

endmodule

// File: logic/cpu_top.sv
module cpu_top (
	input  logic                        clk,
	input  logic                        nRst,
	output logic                        wb_cyc,
	output logic                        wb_stb,
	output logic                        wb_we,
	output logic [cpu_pkg::data_w-1:0]  wb_adr,
	output logic [cpu_pkg::data_w-1:0]  wb_dat_w,
	input  logic [cpu_pkg::data_w-1:0]  wb_dat_r,
	input  logic                        wb_ack,
	output logic                        halted
);

	cpu_ctrl_if i_ctrl_if ();
	cpu_bus_if  i_bus_if ();

	cpu_controller i_controller (
		.clk    (clk),
		.nRst   (nRst),
		.ctrl   (i_ctrl_if.ctrl),
		.bus    (i_bus_if.ctrl),
		.halted (halted)
	);

	cpu_datapath i_datapath (
		.clk  (clk),
		.nRst (nRst),
		.ctrl (i_ctrl_if.dp),
		.bus  (i_bus_if.dp)
	);

	cpu_bus_master i_bus_master (
		.clk      (clk),
		.nRst     (nRst),
		.bus      (i_bus_if.master),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

endmodule

// File: verif/cpu_sva.sv
module cpu_sva (
	input logic                        clk,
	input logic                        nRst,
	input logic                        wb_cyc,
	input logic                        wb_stb,
	input logic                        wb_we,
	input logic [cpu_pkg::data_w-1:0]  wb_adr,
	input logic [cpu_pkg::data_w-1:0]  wb_dat_w,
	input logic [cpu_pkg::data_w-1:0]  wb_dat_r,
	input logic                        wb_ack,
	input logic                        halted,
	input cpu_pkg::state_e             state
);

	logic                       cyc_q;
	logic [1:0]                 open_count;
	logic [cpu_pkg::data_w-1:0] vec_val;

	logic stb_cyc_bad = 1'b0;
	logic stable_bad = 1'b0;
	logic idle_bad = 1'b0;
	logic halt_bad = 1'b0;
	logic state_bad = 1'b0;
	logic region_bad = 1'b0;
	logic vector_bad = 1'b0;
	logic start_bad = 1'b0;
	logic any_failed;

	assign any_failed = stb_cyc_bad | stable_bad | idle_bad | halt_bad | state_bad |
		region_bad | vector_bad | start_bad;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			cyc_q      <= 1'b0;
			open_count <= 2'd0;
			vec_val    <= '0;
		end else begin
			cyc_q <= wb_cyc;
			if (wb_cyc && !cyc_q && open_count != 2'd3)
				open_count <= open_count + 2'd1;
			// the first read returns the start vector.
			if (wb_cyc && wb_ack && open_count == 2'd1)
				vec_val <= wb_dat_r;
		end
	end

	assert property (@(posedge clk) disable iff (!nRst) wb_stb |-> wb_cyc)
		else begin
			stb_cyc_bad = 1'b1;
			$error("strobe high without cycle");
		end

	assert property (@(posedge clk) disable iff (!nRst)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
		else begin
			stable_bad = 1'b1;
			$error("bus changed while waiting for ack");
		end

	assert property (@(posedge clk) disable iff (!nRst) wb_stb && wb_ack |=> !wb_cyc)
		else begin
			idle_bad = 1'b1;
			$error("no idle cycle after ack");
		end

	assert property (@(posedge clk) disable iff (!nRst) halted |=> halted && !wb_cyc)
		else begin
			halt_bad = 1'b1;
			$error("halted dropped or bus active after halt");
		end

	// a HALT is only acted on in DECODE, when no bus cycle is open.
	assert property (@(posedge clk) disable iff (!nRst)
		$rose(halted) |-> $past(state) == cpu_pkg::DECODE && !wb_cyc)
		else begin
			state_bad = 1'b1;
			$error("halted did not follow a decoded HALT instruction");
		end

	// stores only go to the marker region or the stack.
	assert property (@(posedge clk) disable iff (!nRst)
		wb_cyc && wb_we |-> (wb_adr[7:4] == 4'h8 || wb_adr >= 8'hF0))
		else begin
			region_bad = 1'b1;
			$error("write outside marker and stack regions");
		end

	assert property (@(posedge clk) disable iff (!nRst)
		wb_cyc && !cyc_q && open_count == 2'd0 |-> !wb_we && wb_adr == cpu_pkg::vector_addr)
		else begin
			vector_bad = 1'b1;
			$error("first bus cycle is not a vector read");
		end

	assert property (@(posedge clk) disable iff (!nRst)
		wb_cyc && !cyc_q && open_count == 2'd1 |-> !wb_we && wb_adr == vec_val)
		else begin
			start_bad = 1'b1;
			$error("second bus cycle is not a fetch at the start vector");
		end

endmodule

bind cpu_top cpu_sva i_cpu_sva (
	.clk      (clk),
	.nRst     (nRst),
	.wb_cyc   (wb_cyc),
	.wb_stb   (wb_stb),
	.wb_we    (wb_we),
	.wb_adr   (wb_adr),
	.wb_dat_w (wb_dat_w),
	.wb_dat_r (wb_dat_r),
	.wb_ack   (wb_ack),
	.halted   (halted),
	.state    (i_controller.state)
);

// File: verif/cpu_tb.sv
module cpu_tb;

	localparam int n_writes = 13;
	localparam int code_len = 76;
	localparam int halt_timeout = 5000;
	localparam int halt_hold_cycles = 50;

	logic       clk;
	logic       nRst;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	logic [7:0] wb_adr;
	logic [7:0] wb_dat_w;
	logic [7:0] wb_dat_r;
	logic       wb_ack;
	logic       halted;

	logic [7:0] mem [256];
	logic [7:0] exp_adr [n_writes];
	logic [7:0] exp_dat [n_writes];
	int         wr_idx;
	int         wait_left;

	// main program from 0x10 up to the HALT at 0x5B.
	logic [7:0] code [code_len] = '{
		8'h40, 8'h3C, 8'h44, 8'h15, 8'h4C, 8'h80, 8'h01, 8'h63,
		8'h40, 8'h3C, 8'h4C, 8'h81, 8'h11, 8'h63, 8'h40, 8'h3C,
		8'h4C, 8'h82, 8'h21, 8'h63, 8'h40, 8'h3C, 8'h4C, 8'h83,
		8'h31, 8'h63, 8'h48, 8'hC0, 8'h52, 8'h4C, 8'h84, 8'h63,
		8'h4C, 8'h85, 8'h15, 8'h73, 8'h40, 8'h5A, 8'h63, 8'h40,
		8'hA5, 8'h63, 8'h4C, 8'h86, 8'h44, 8'h07, 8'h40, 8'h02,
		8'h01, 8'h73, 8'h40, 8'h5A, 8'h63, 8'h1A, 8'h73, 8'h40,
		8'hA5, 8'h63, 8'h40, 8'h11, 8'h44, 8'h22, 8'h90, 8'h94,
		8'h80, 8'h60, 8'hA8, 8'hAC, 8'h44, 8'h88, 8'h69, 8'h44,
		8'h89, 8'h6D, 8'hC0, 8'hF0
	};

	// subroutine at 0x60.
	logic [7:0] sub_code [6] = '{8'h40, 8'hC3, 8'h44, 8'h87, 8'h61, 8'hB0};

	// ALU results, load, branch markers, then the stack traffic in write order.
	logic [7:0] table_adr [n_writes] = '{
		8'h80, 8'h81, 8'h82, 8'h83, 8'h84, 8'h85, 8'h86,
		8'hFF, 8'hFE, 8'hFD, 8'h87, 8'h88, 8'h89
	};
	logic [7:0] table_dat [n_writes] = '{
		8'h51, 8'h27, 8'h14, 8'h29, 8'h6B, 8'hA5, 8'h5A,
		8'h11, 8'h22, 8'h52, 8'hC3, 8'h22, 8'h11
	};

	cpu_top i_cpu_top (
		.clk      (clk),
		.nRst     (nRst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.halted   (halted)
	);

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic load_memory();
		for (int a = 0; a < 256; a++)
			mem[a] = 8'(a) ^ 8'h5C;
		mem[0] = 8'h10;
		for (int i = 0; i < code_len; i++)
			mem[8'h10 + i] = code[i];
		for (int i = 0; i < 6; i++)
			mem[8'h60 + i] = sub_code[i];
		mem[8'hC0] = 8'h6B;
		for (int i = 0; i < n_writes; i++) begin
			exp_adr[i] = table_adr[i];
			exp_dat[i] = table_dat[i];
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// the memory model answers each strobe after 0 to 3 wait cycles.
	initial begin
		void'($urandom(32'h19bd02bd));
		wait_left = -1;
		forever begin
			@(negedge clk);
			if (wb_ack) begin
				wb_ack    = 1'b0;
				wait_left = -1;
			end else if (nRst && wb_stb) begin
				if (wait_left < 0)
					wait_left = int'($urandom % 4);
				if (wait_left == 0) begin
					wb_ack = 1'b1;
					if (wb_we) begin
						assert (wr_idx < n_writes && wb_adr == exp_adr[wr_idx] &&
							wb_dat_w == exp_dat[wr_idx])
						else
							stop_run($sformatf("[ERROR] %0t: write %0d got %02h <= %02h",
								$time, wr_idx, wb_adr, wb_dat_w));
						mem[wb_adr] = wb_dat_w;
						wr_idx++;
					end else begin
						wb_dat_r = mem[wb_adr];
					end
				end else begin
					wait_left--;
				end
			end
		end
	end

	initial begin
		forever begin
			@(negedge clk);
			if (i_cpu_top.i_cpu_sva.any_failed)
				stop_run("a bus protocol assertion failed");
		end
	end

	initial begin
		int cycles;
		nRst     = 1'b0;
		wb_ack   = 1'b0;
		wb_dat_r = 8'h00;
		wr_idx   = 0;
		load_memory();
		repeat (5) @(negedge clk);
		nRst = 1'b1;
		cycles = 0;
		while (!halted && cycles < halt_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted)
			stop_run("timeout while waiting for the CPU to halt");
		// let the halted state run for a while so the bound checks see it hold.
		cycles = 0;
		while (cycles < halt_hold_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (wr_idx != n_writes) begin
			stop_run($sformatf("[ERROR] %0t: saw %0d writes, expected %0d",
				$time, wr_idx, n_writes));
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// File: vlog.f
logic/cpu_pkg.sv
logic/cpu_ctrl_if.sv
logic/cpu_bus_if.sv
logic/cpu_controller.sv
logic/cpu_datapath.sv
logic/cpu_bus_master.sv
logic/cpu_top.sv
verif/cpu_sva.sv
verif/cpu_tb.sv

// File: Makefile
# Verilator build and run for the 8-bit CPU testbench.

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard logic/*.sv) $(wildcard verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
